// ==== src/sysarr_params.svh ====
////////////////////
// Array size and datapath widths for RTL and testbench
// SYSARR_N must be at least 2; results wrap at SYSARR_ACC_W bits
////////////////////
`ifndef SYSARR_PARAMS_SVH
`define SYSARR_PARAMS_SVH

// Array dimension, also the vector length
`define SYSARR_N 4

// Signed input element width
`define SYSARR_ELEM_W 16

// Signed result width
`define SYSARR_ACC_W 32

// Width of the commanded vector count
`define SYSARR_CNT_W 8

`endif

// ==== src/sysarr_data_pkg.sv ====
////////////////////
// Datapath types; element 0 sits in the lowest bits of a vector
////////////////////
`default_nettype none

`include "sysarr_params.svh"

package sysarr_data_pkg;

  ////////////////////
  // Scalars
  ////////////////////

  // One signed input element
  typedef logic signed [`SYSARR_ELEM_W-1:0] elem_t;

  // One signed result, wraps modulo 2^ACC_W
  typedef logic signed [`SYSARR_ACC_W-1:0] acc_t;

  ////////////////////
  // Vectors
  ////////////////////

  // Weight row or input vector
  typedef elem_t [`SYSARR_N-1:0] vec_t;

  // Result vector
  typedef acc_t [`SYSARR_N-1:0] res_vec_t;

  // Bottom of one array column, tagged so bubbles can be dropped
  typedef struct packed {
    logic valid;
    acc_t sum;
  } col_out_t;

endpackage : sysarr_data_pkg

`default_nettype wire

// ==== src/sysarr_ctrl_pkg.sv ====
////////////////////
// Kernel control types
////////////////////
`default_nettype none

`include "sysarr_params.svh"

package sysarr_ctrl_pkg;

  // Bits needed to select one weight row
  localparam int ROW_W = $clog2(`SYSARR_N);

  // Kernel phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOAD,
    ST_RUN,
    ST_FLUSH
  } kernel_state_e;

  // Captured on the start edge
  typedef struct packed {
    logic [`SYSARR_CNT_W-1:0] vector_count;
  } kernel_cmd_t;

  // Per-cycle commands to the array
  typedef struct packed {
    logic             load_en;
    logic [ROW_W-1:0] load_row;
    logic             advance;
    logic             inject;
  } array_ctrl_t;

endpackage : sysarr_ctrl_pkg

`default_nettype wire

// ==== src/mac_cell.sv ====
////////////////////
// Weight-stationary PE; registers step only on advance
////////////////////
`timescale 1ns/1ps
`default_nettype none

module mac_cell
  import sysarr_data_pkg::*;
(
  input  wire        ap_clk,
  input  wire        areset,
  input  wire        load_en,
  input  wire elem_t w_in,
  input  wire        advance,
  input  wire elem_t x_in,
  input  wire        x_tag_in,
  input  wire acc_t  psum_in,
  output elem_t      x_out,
  output logic       x_tag_out,
  output acc_t       psum_out
);

  elem_t weight;
  acc_t  product;

  // Stationary weight, loaded once per command
  always_ff @(posedge ap_clk) begin
    if (load_en) begin
      weight <= w_in;
    end
  end

  // Sign-extend both, keep the low ACC_W bits
  assign product = acc_t'(x_in) * acc_t'(weight);

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      x_tag_out <= 1'b0;
    end else if (advance) begin
      x_tag_out <= x_tag_in;
    end
  end

  // Input moves right, partial sum moves down
  always_ff @(posedge ap_clk) begin
    if (advance) begin
      x_out    <= x_in;
      psum_out <= psum_in + product;
    end
  end

endmodule : mac_cell

`default_nettype wire

// ==== src/systolic_array.sv ====
////////////////////
// Row k input is delayed k steps; column j finishes j steps after column 0
// Nothing moves while advance is low
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sysarr_params.svh"

module systolic_array
  import sysarr_data_pkg::*;
  import sysarr_ctrl_pkg::*;
(
  input  wire                      ap_clk,
  input  wire                      areset,
  input  wire array_ctrl_t         actl,
  input  wire vec_t                w_row,
  input  wire vec_t                x_vec,
  output col_out_t [`SYSARR_N-1:0] col_out
);

  localparam int N = `SYSARR_N;

  // Horizontal links, index j is the input of column j
  elem_t x_h   [N][N+1];
  logic  tag_h [N][N+1];
  // Vertical links, index k is the input of row k
  acc_t  psum_v [N+1][N];

  for (genvar k = 0; k < N; k++) begin : g_row

    ////////////////////
    // Input skew
    ////////////////////
    if (k == 0) begin : g_direct
      assign x_h[k][0]   = x_vec[k];
      assign tag_h[k][0] = actl.inject;
    end else begin : g_skew
      elem_t        sk_x [k];
      logic [k-1:0] sk_tag;

      // Tag bits mark bubbles and are cleared on reset
      always_ff @(posedge ap_clk) begin
        if (areset) begin
          sk_tag <= '0;
        end else if (actl.advance) begin
          sk_tag[0] <= actl.inject;
          for (int s = 1; s < k; s++) begin
            sk_tag[s] <= sk_tag[s-1];
          end
        end
      end

      always_ff @(posedge ap_clk) begin
        if (actl.advance) begin
          sk_x[0] <= x_vec[k];
          for (int s = 1; s < k; s++) begin
            sk_x[s] <= sk_x[s-1];
          end
        end
      end

      assign x_h[k][0]   = sk_x[k-1];
      assign tag_h[k][0] = sk_tag[k-1];
    end

    ////////////////////
    // PE row k holds W[k][*]
    ////////////////////
    for (genvar j = 0; j < N; j++) begin : g_col
      mac_cell mac_cell_i (
        .ap_clk    (ap_clk),
        .areset    (areset),
        .load_en   (actl.load_en && (actl.load_row == ROW_W'(k))),
        .w_in      (w_row[j]),
        .advance   (actl.advance),
        .x_in      (x_h[k][j]),
        .x_tag_in  (tag_h[k][j]),
        .psum_in   (psum_v[k][j]),
        .x_out     (x_h[k][j+1]),
        .x_tag_out (tag_h[k][j+1]),
        .psum_out  (psum_v[k+1][j])
      );
    end
  end

  // Top row starts every column from zero
  for (genvar j = 0; j < N; j++) begin : g_seed
    assign psum_v[0][j] = '0;
  end

  // The bottom-row tag travels with the finished sum of its column
  always_comb begin
    for (int j = 0; j < N; j++) begin
      col_out[j].valid = tag_h[N-1][j+1];
      col_out[j].sum   = psum_v[N][j];
    end
  end

endmodule : systolic_array

`default_nettype wire

// ==== src/result_deskew.sv ====
////////////////////
// Aligned results are written on the advance step that consumes them
// can_advance holds the array whenever that write would overflow the FIFO
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sysarr_params.svh"

module result_deskew
  import sysarr_data_pkg::*;
(
  input  wire                           ap_clk,
  input  wire                           areset,
  input  wire                           advance,
  input  wire col_out_t [`SYSARR_N-1:0] col_out,
  input  wire                           y_ready,
  output logic                          y_valid,
  output res_vec_t                      y_data,
  output logic                          y_fire,
  output logic                          can_advance
);

  localparam int N = `SYSARR_N;

  acc_t       al_sum   [N];
  logic       al_valid [N];
  logic       al_all;
  res_vec_t   al_vec;
  res_vec_t   fifo_mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;

  ////////////////////
  // Column delays
  ////////////////////
  for (genvar j = 0; j < N; j++) begin : g_col
    localparam int D = N - 1 - j;
    if (D == 0) begin : g_pass
      assign al_sum[j]   = col_out[j].sum;
      assign al_valid[j] = col_out[j].valid;
    end else begin : g_dly
      acc_t         sum_q [D];
      logic [D-1:0] vld_q;

      always_ff @(posedge ap_clk) begin
        if (areset) begin
          vld_q <= '0;
        end else if (advance) begin
          vld_q[0] <= col_out[j].valid;
          for (int s = 1; s < D; s++) begin
            vld_q[s] <= vld_q[s-1];
          end
        end
      end

      always_ff @(posedge ap_clk) begin
        if (advance) begin
          sum_q[0] <= col_out[j].sum;
          for (int s = 1; s < D; s++) begin
            sum_q[s] <= sum_q[s-1];
          end
        end
      end

      assign al_sum[j]   = sum_q[D-1];
      assign al_valid[j] = vld_q[D-1];
    end
  end

  always_comb begin
    al_all = 1'b1;
    for (int j = 0; j < N; j++) begin
      al_all    = al_all & al_valid[j];
      al_vec[j] = al_sum[j];
    end
  end

  ////////////////////
  // Two-entry FIFO
  ////////////////////
  assign push        = advance & al_all;
  assign y_valid     = (count != 2'd0);
  assign y_data      = fifo_mem[rd_ptr];
  assign y_fire      = y_valid & y_ready;
  // A pending aligned result needs one free slot before the next step
  assign can_advance = (count != 2'd2) | ~al_all;

  always_ff @(posedge ap_clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= al_vec;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (y_fire) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({push, y_fire})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

endmodule : result_deskew

`default_nettype wire

// ==== src/kernel_ctrl.sv ====
////////////////////
// Start is only seen as a rising edge while idle; busy starts are dropped
// Gating the array on can_advance happens here and nowhere else
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sysarr_params.svh"

module kernel_ctrl
  import sysarr_ctrl_pkg::*;
(
  input  wire              ap_clk,
  input  wire              areset,
  input  wire              ap_start,
  input  wire kernel_cmd_t cmd,
  input  wire              w_valid,
  input  wire              x_valid,
  input  wire              can_advance,
  input  wire              y_fire,
  output logic             w_ready,
  output logic             x_ready,
  output array_ctrl_t      actl,
  output logic             ap_idle,
  output logic             ap_done,
  output logic             ap_ready
);

  kernel_state_e            state;
  kernel_cmd_t              cmd_q;
  logic                     start_q;
  logic                     start_pulse;
  logic                     w_fire;
  logic                     done_q;
  logic [ROW_W-1:0]         row_cnt;
  logic [`SYSARR_CNT_W-1:0] in_cnt;
  logic [`SYSARR_CNT_W-1:0] out_cnt;
  logic [`SYSARR_CNT_W-1:0] last_idx;

  assign start_pulse = ap_start & ~start_q;
  assign last_idx    = cmd_q.vector_count - 1'b1;

  assign w_ready = (state == ST_LOAD);
  assign x_ready = (state == ST_RUN) & can_advance;
  assign w_fire  = w_valid & w_ready;

  always_comb begin
    actl.load_en  = w_fire;
    actl.load_row = row_cnt;
    // Bubbles keep flowing in RUN even without input
    actl.advance  = ((state == ST_RUN) || (state == ST_FLUSH)) && can_advance;
    actl.inject   = x_valid && x_ready;
  end

  assign ap_idle  = (state == ST_IDLE);
  assign ap_done  = done_q;
  assign ap_ready = done_q;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= ap_start;
    end
  end

  ////////////////////
  // Phase FSM
  ////////////////////
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      state   <= ST_IDLE;
      cmd_q   <= '0;
      row_cnt <= '0;
      in_cnt  <= '0;
      out_cnt <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start_pulse) begin
            cmd_q   <= cmd;
            row_cnt <= '0;
            in_cnt  <= '0;
            out_cnt <= '0;
            state   <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          if (w_fire) begin
            row_cnt <= row_cnt + 1'b1;
            if (row_cnt == ROW_W'(`SYSARR_N - 1)) begin
              // Zero vectors means nothing to wait for
              if (cmd_q.vector_count == '0) begin
                state  <= ST_IDLE;
                done_q <= 1'b1;
              end else begin
                state <= ST_RUN;
              end
            end
          end
        end
        ST_RUN: begin
          if (actl.inject) begin
            in_cnt <= in_cnt + 1'b1;
            if (in_cnt == last_idx) begin
              state <= ST_FLUSH;
            end
          end
          if (y_fire) begin
            out_cnt <= out_cnt + 1'b1;
          end
        end
        ST_FLUSH: begin
          if (y_fire) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_cnt == last_idx) begin
              state  <= ST_IDLE;
              done_q <= 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule : kernel_ctrl

`default_nettype wire

// ==== src/sysarr_top.sv ====
////////////////////
// Kernel top: N weight rows first, then cmd.vector_count input vectors
// y = x * W per vector, in input order, wrapped to 32 bits
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sysarr_params.svh"

module sysarr_top
  import sysarr_data_pkg::*;
  import sysarr_ctrl_pkg::*;
(
  input  wire              ap_clk,
  input  wire              areset,
  // Kernel control
  input  wire              ap_start,
  input  wire kernel_cmd_t cmd,
  output wire              ap_idle,
  output wire              ap_done,
  output wire              ap_ready,
  // Weight stream, one row per beat
  input  wire              w_valid,
  input  wire vec_t        w_data,
  output wire              w_ready,
  // Input vector stream
  input  wire              x_valid,
  input  wire vec_t        x_data,
  output wire              x_ready,
  // Result stream
  output wire              y_valid,
  output wire res_vec_t    y_data,
  input  wire              y_ready
);

  array_ctrl_t              actl;
  col_out_t [`SYSARR_N-1:0] col_out;
  logic                     can_advance;
  logic                     y_fire;

  kernel_ctrl kernel_ctrl_i (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .ap_start    (ap_start),
    .cmd         (cmd),
    .w_valid     (w_valid),
    .x_valid     (x_valid),
    .can_advance (can_advance),
    .y_fire      (y_fire),
    .w_ready     (w_ready),
    .x_ready     (x_ready),
    .actl        (actl),
    .ap_idle     (ap_idle),
    .ap_done     (ap_done),
    .ap_ready    (ap_ready)
  );

  systolic_array systolic_array_i (
    .ap_clk  (ap_clk),
    .areset  (areset),
    .actl    (actl),
    .w_row   (w_data),
    .x_vec   (x_data),
    .col_out (col_out)
  );

  result_deskew result_deskew_i (
    .ap_clk      (ap_clk),
    .areset      (areset),
    .advance     (actl.advance),
    .col_out     (col_out),
    .y_ready     (y_ready),
    .y_valid     (y_valid),
    .y_data      (y_data),
    .y_fire      (y_fire),
    .can_advance (can_advance)
  );

endmodule : sysarr_top

`default_nettype wire

// ==== testbench/tb_sysarr_checks.svh ====
////////////////////
// Included inside tb_sysarr; relies on its checks and errors counters
// Reference model sums in 64 bits and wraps to SYSARR_ACC_W
////////////////////
`ifndef TB_SYSARR_CHECKS_SVH
`define TB_SYSARR_CHECKS_SVH

// Source of input vectors
logic [31:0] rng_state;

////////////////////
// Random numbers
////////////////////

// One 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] r;
  r = s ^ (s << 13);
  r = r ^ (r >> 17);
  r = r ^ (r << 5);
  return r;
endfunction

// True for about pct percent of calls on one stream
function automatic logic roll_percent(inout logic [31:0] state, input int pct);
  state = xorshift32(state);
  return (state % 32'd100) < 32'(pct);
endfunction

function automatic vec_t random_vec();
  vec_t v;
  for (int k = 0; k < `SYSARR_N; k++) begin
    rng_state = xorshift32(rng_state);
    v[k]      = elem_t'(rng_state[`SYSARR_ELEM_W-1:0]);
  end
  return v;
endfunction

////////////////////
// Reference model
////////////////////

// y[j] is the sum over k of x[k] * W[k][j]
function automatic res_vec_t expected_product(input vec_t x, input vec_t wmat [`SYSARR_N]);
  res_vec_t y;
  longint   sum;
  for (int j = 0; j < `SYSARR_N; j++) begin
    sum = 0;
    for (int k = 0; k < `SYSARR_N; k++) begin
      sum = sum + longint'($signed(x[k])) * longint'($signed(wmat[k][j]));
    end
    y[j] = acc_t'(sum);
  end
  return y;
endfunction

////////////////////
// Checks
////////////////////

task automatic compare_res_vec(input string name, input res_vec_t got, input res_vec_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Fail %s: got %h expected %h at time %0t", name, got, exp, $time);
  end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("Fail %s: got %h expected %h at time %0t", name, got, exp, $time);
  end
endtask

// Ordering, count and protocol problems
task automatic report_problem(input string what);
  errors++;
  $display("Error: %s at time %0t", what, $time);
endtask

`endif

// ==== testbench/tb_sysarr.sv ====
////////////////////
// Testbench for sysarr_top; weight seed 0 in the table selects identity
// Watchdog allows 200 cycles plus 20 per vector over the whole table
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sysarr_params.svh"

module tb_sysarr
  import sysarr_data_pkg::*;
  import sysarr_ctrl_pkg::*;
();

  localparam int N         = `SYSARR_N;
  localparam int NUM_CASES = 5;
  localparam int MAX_VECS  = 64;

  // Weight seed, vector count, x gap %, y stall %, start pulse while busy
  typedef struct packed {
    logic [31:0] wseed;
    logic [7:0]  count;
    logic [7:0]  x_gap;
    logic [7:0]  y_stall;
    logic        busy_start;
  } case_t;

  localparam case_t CASES [NUM_CASES] = '{
    '{32'd0,      8'd1,  8'd0,  8'd0,  1'b0},
    '{32'h1d2c,   8'd32, 8'd0,  8'd0,  1'b0},
    '{32'h3a71,   8'd24, 8'd0,  8'd40, 1'b0},
    '{32'h0b5e,   8'd24, 8'd35, 8'd0,  1'b0},
    '{32'h6f13,   8'd20, 8'd30, 8'd30, 1'b1}
  };

  logic        ap_clk;
  logic        areset;
  logic        ap_start;
  kernel_cmd_t cmd;
  logic        ap_idle;
  logic        ap_done;
  logic        ap_ready;
  logic        w_valid;
  vec_t        w_data;
  logic        w_ready;
  logic        x_valid;
  vec_t        x_data;
  logic        x_ready;
  logic        y_valid;
  res_vec_t    y_data;
  logic        y_ready;

  int          checks;
  int          errors;
  int          done_seen;
  logic [31:0] gap_state;
  logic [31:0] stall_state;
  vec_t        wmat  [N];
  vec_t        xs    [MAX_VECS];
  res_vec_t    exp_y [MAX_VECS];

  `include "tb_sysarr_checks.svh"

  always #2 ap_clk = ~ap_clk;

  // Every ap_done pulse, wanted or not
  always @(posedge ap_clk) begin
    if (!areset && ap_done) begin
      done_seen++;
    end
  end

  sysarr_top sysarr_top_i (
    .ap_clk   (ap_clk),
    .areset   (areset),
    .ap_start (ap_start),
    .cmd      (cmd),
    .ap_idle  (ap_idle),
    .ap_done  (ap_done),
    .ap_ready (ap_ready),
    .w_valid  (w_valid),
    .w_data   (w_data),
    .w_ready  (w_ready),
    .x_valid  (x_valid),
    .x_data   (x_data),
    .x_ready  (x_ready),
    .y_valid  (y_valid),
    .y_data   (y_data),
    .y_ready  (y_ready)
  );

  ////////////////////
  // Case setup
  ////////////////////
  task automatic prepare_case(input case_t c);
    logic [31:0] ws;
    ws = c.wseed;
    for (int k = 0; k < N; k++) begin
      for (int j = 0; j < N; j++) begin
        if (c.wseed == 0) begin
          wmat[k][j] = (k == j) ? elem_t'(1) : elem_t'(0);
        end else begin
          ws         = xorshift32(ws);
          wmat[k][j] = elem_t'(ws[`SYSARR_ELEM_W-1:0]);
        end
      end
    end
    for (int v = 0; v < int'(c.count); v++) begin
      xs[v] = random_vec();
      if (c.wseed == 0) begin
        // Identity weights return x sign-extended
        for (int j = 0; j < N; j++) begin
          exp_y[v][j] = acc_t'($signed(xs[v][j]));
        end
      end else begin
        exp_y[v] = expected_product(xs[v], wmat);
      end
    end
  endtask

  ////////////////////
  // Stream drivers and monitor
  ////////////////////
  task automatic load_weights(input case_t c);
    int row;
    row = 0;
    @(posedge ap_clk);
    ap_start <= 1'b1;
    cmd      <= '{vector_count: c.count};
    @(posedge ap_clk);
    ap_start <= 1'b0;
    w_valid  <= 1'b1;
    w_data   <= wmat[0];
    @(posedge ap_clk);
    compare_bit("ap_idle", ap_idle, 1'b0);
    compare_bit("w_ready", w_ready, 1'b1);
    while (row < N) begin
      if (w_ready) begin
        row++;
        if (row < N) begin
          w_data <= wmat[row];
        end else begin
          w_valid <= 1'b0;
        end
      end
      if (row < N) begin
        @(posedge ap_clk);
      end
    end
  endtask

  task automatic send_inputs(input case_t c);
    int sent;
    int cycle;
    sent  = 0;
    cycle = 0;
    while (sent < int'(c.count)) begin
      @(posedge ap_clk);
      cycle++;
      // Start pulse in the middle of a command, must be ignored
      ap_start <= c.busy_start && (cycle == 3);
      if (x_valid && x_ready) begin
        sent++;
      end
      if (x_ready || !x_valid) begin
        if (sent < int'(c.count) && !roll_percent(gap_state, int'(c.x_gap))) begin
          x_valid <= 1'b1;
          x_data  <= xs[sent];
        end else begin
          x_valid <= 1'b0;
        end
      end
    end
    ap_start <= 1'b0;
  endtask

  task automatic collect_outputs(input case_t c);
    int       got;
    logic     held;
    res_vec_t held_data;
    got       = 0;
    held      = 1'b0;
    held_data = '0;
    while (got < int'(c.count)) begin
      @(posedge ap_clk);
      // A stalled beat keeps valid and data until taken
      if (held) begin
        compare_bit("y_valid", y_valid, 1'b1);
        compare_res_vec("y_data", y_data, held_data);
      end
      if (ap_done) begin
        report_problem("ap_done came before all results were taken");
      end
      if (y_valid && y_ready) begin
        compare_res_vec("y_data", y_data, exp_y[got]);
        got++;
      end
      held      = y_valid && !y_ready;
      held_data = y_data;
      y_ready <= !roll_percent(stall_state, int'(c.y_stall));
    end
    y_ready <= 1'b0;
  endtask

  task automatic run_case(input int idx, input case_t c);
    int   err0;
    int   done0;
    logic extra;
    err0  = errors;
    done0 = done_seen;
    extra = 1'b0;
    prepare_case(c);
    load_weights(c);
    fork
      send_inputs(c);
      collect_outputs(c);
    join
    // Cycle after the last y beat
    @(posedge ap_clk);
    compare_bit("ap_done", ap_done, 1'b1);
    compare_bit("ap_ready", ap_ready, 1'b1);
    compare_bit("ap_idle", ap_idle, 1'b1);
    @(posedge ap_clk);
    compare_bit("ap_done", ap_done, 1'b0);
    compare_bit("ap_ready", ap_ready, 1'b0);
    compare_bit("ap_idle", ap_idle, 1'b1);
    repeat (2 * N + 4) begin
      @(posedge ap_clk);
      if (y_valid && !extra) begin
        extra = 1'b1;
        report_problem("extra result vector after the last expected one");
      end
    end
    if (done_seen - done0 != 1) begin
      report_problem($sformatf("%0d ap_done pulses for one command", done_seen - done0));
    end
    $display("case %0d: %0d vectors, %0d errors", idx, c.count, errors - err0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    ap_clk      = 1'b0;
    areset      = 1'b1;
    ap_start    = 1'b0;
    cmd         = '0;
    w_valid     = 1'b0;
    w_data      = '0;
    x_valid     = 1'b0;
    x_data      = '0;
    y_ready     = 1'b0;
    checks      = 0;
    errors      = 0;
    done_seen   = 0;
    rng_state   = 32'd14627;
    gap_state   = xorshift32(rng_state);
    stall_state = xorshift32(gap_state);
    repeat (16) @(posedge ap_clk);
    areset <= 1'b0;
    @(posedge ap_clk);
    compare_bit("ap_idle", ap_idle, 1'b1);
    compare_bit("ap_done", ap_done, 1'b0);
    compare_bit("ap_ready", ap_ready, 1'b0);
    compare_bit("w_ready", w_ready, 1'b0);
    compare_bit("x_ready", x_ready, 1'b0);
    compare_bit("y_valid", y_valid, 1'b0);
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(i, CASES[i]);
    end
    if (done_seen != NUM_CASES) begin
      report_problem("ap_done pulse count differs from the number of commands");
    end
    $display("checks %0d, errors %0d, ap_done pulses %0d", checks, errors, done_seen);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int limit;
    limit = 200;
    for (int i = 0; i < NUM_CASES; i++) begin
      limit += 20 * int'(CASES[i].count);
    end
    repeat (limit) @(posedge ap_clk);
    $display("Error: watchdog expired after %0d cycles, the DUT stopped responding", limit);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule : tb_sysarr

`default_nettype wire

// ==== sim.f ====
+incdir+src
+incdir+testbench
src/sysarr_data_pkg.sv
src/sysarr_ctrl_pkg.sv
src/mac_cell.sv
src/systolic_array.sv
src/result_deskew.sv
src/kernel_ctrl.sv
src/sysarr_top.sv
testbench/tb_sysarr.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the systolic array testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_sysarr -o Vtb_sysarr

./obj_dir/Vtb_sysarr | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "run_sim: simulation passed"
else
  echo "run_sim: simulation did not pass, see sim.log"
  exit 1
fi
